//--- Bender.yml
package:
  name: nabp

sources:
  - files:
      - source/nabp_pkg.sv
      - source/nabp_sinogram_addresser.sv
      - source/nabp_filter.sv
      - source/nabp_filtered_ram_swap_control.sv
      - source/nabp_processing_swap_control.sv
      - source/nabp_processing_element.sv
      - source/nabp_image_addresser.sv
      - source/nabp.sv
  - target: test
    files:
      - verification/nabp_tb_clock.sv
      - verification/nabp_tb.sv

//--- source/nabp.sv
`timescale 1ns/100ps

module nabp import nabp_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             sg_kick,
    input  logic [k_data_width-1:0]          sg_val,
    input  logic                             ir_enable,
    output logic                             sg_done,
    output logic                             sg_read,
    output logic [k_sinogram_addr_width-1:0] sg_addr,
    output logic                             ir_kick,
    output logic                             ir_done,
    output logic                             ir_addr_valid,
    output logic [k_image_addr_width-1:0]    ir_addr,
    output logic signed [k_cache_width-1:0]  ir_val
);

    // sinogram side
    sample_tag_t      sample_tag;
    filtered_sample_t filtered;
    logic             bank_stored;
    logic             bank_free;

    // bank to processing side
    logic             bank_release;
    logic             rd_full;
    projection_t      rd_angle;
    line_t            rd_line;
    pe_command_t      pe_command;

    // readout chain, element i sits between entries i and i+1
    logic [k_partition_count:0]      domino;
    logic signed [k_cache_width-1:0] domino_val [k_partition_count+1];

    assign domino[0]     = sg_done;
    assign domino_val[0] = '0;
    assign ir_val        = domino_val[k_partition_count];

    nabp_sinogram_addresser sinogram_addresser (
        .clk         (clk),
        .reset       (reset),
        .sg_kick     (sg_kick),
        .bank_stored (bank_stored),
        .bank_free   (bank_free),
        .sg_read     (sg_read),
        .sg_addr     (sg_addr),
        .sample_tag  (sample_tag)
    );

    nabp_filter filter (
        .clk        (clk),
        .reset      (reset),
        .sample_tag (sample_tag),
        .sg_val     (sg_val),
        .filtered   (filtered)
    );

    nabp_filtered_ram_swap_control filtered_ram_swap_control (
        .clk          (clk),
        .reset        (reset),
        .filtered     (filtered),
        .bank_release (bank_release),
        .bank_stored  (bank_stored),
        .bank_free    (bank_free),
        .rd_full      (rd_full),
        .rd_angle     (rd_angle),
        .rd_line      (rd_line)
    );

    nabp_processing_swap_control processing_swap_control (
        .clk          (clk),
        .reset        (reset),
        .rd_full      (rd_full),
        .rd_angle     (rd_angle),
        .pe_command   (pe_command),
        .bank_release (bank_release),
        .sg_done      (sg_done)
    );

    // command and taps broadcast to every element
    for (genvar i = 0; i < k_partition_count; i++) begin : g_pe
        nabp_processing_element #(
            .pe_id (i)
        ) processing_element (
            .clk         (clk),
            .reset       (reset),
            .pe_command  (pe_command),
            .taps        (rd_line),
            .ir_enable   (ir_enable),
            .domino_kick (domino[i]),
            .in_val      (domino_val[i]),
            .domino_done (domino[i+1]),
            .out_val     (domino_val[i+1])
        );
    end

    nabp_image_addresser image_addresser (
        .clk           (clk),
        .reset         (reset),
        .sg_done       (sg_done),
        .ir_enable     (ir_enable),
        .ir_kick       (ir_kick),
        .ir_done       (ir_done),
        .ir_addr_valid (ir_addr_valid),
        .ir_addr       (ir_addr)
    );

endmodule

//--- source/nabp_filter.sv
`timescale 1ns/100ps

module nabp_filter import nabp_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  sample_tag_t             sample_tag,
    input  logic [k_data_width-1:0] sg_val,
    output filtered_sample_t        filtered
);

    logic [k_data_width-1:0] prev_val;
    filtered_value_t         cur_term;
    filtered_value_t         prev_term;

    // twice the sample, zero extended
    assign cur_term  = k_filtered_width'({sg_val, 1'b0});
    // history forgotten at the start of each line
    assign prev_term = (sample_tag.s == '0) ? '0 : k_filtered_width'(prev_val);

    always_ff @(posedge clk) begin
        if (reset) begin
            filtered.valid <= 1'b0;
        end else begin
            filtered.valid <= sample_tag.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_tag.valid) prev_val <= sg_val;
        filtered.angle <= sample_tag.angle;
        filtered.s     <= sample_tag.s;
        filtered.val   <= cur_term - prev_term;
    end

endmodule

//--- source/nabp_filtered_ram_swap_control.sv
`timescale 1ns/100ps

module nabp_filtered_ram_swap_control import nabp_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  filtered_sample_t filtered,
    input  logic             bank_release,
    output logic             bank_stored,
    output logic             bank_free,
    output logic             rd_full,
    output projection_t      rd_angle,
    output line_t            rd_line
);

    // ping-pong line banks
    line_t       bank_line  [2];
    projection_t bank_angle [2];
    logic [1:0]  bank_full;

    // write side follows the filter, read side the processing control
    logic wr_ptr;
    logic rd_ptr;
    logic line_end;

    // last bin of a line completes the bank
    assign line_end    = filtered.valid && (filtered.s == k_s_width'(k_s_count - 1));
    assign bank_stored = line_end;
    assign bank_free   = !bank_full[wr_ptr];

    // read bank seen by the processing side
    assign rd_full  = bank_full[rd_ptr];
    assign rd_angle = bank_angle[rd_ptr];
    assign rd_line  = bank_line[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            bank_full <= '0;
            wr_ptr    <= 1'b0;
            rd_ptr    <= 1'b0;
        end else begin
            // release empties the read bank
            if (bank_release) begin
                bank_full[rd_ptr] <= 1'b0;
                rd_ptr            <= !rd_ptr;
            end
            // never the same bank as the release
            if (line_end) begin
                bank_full[wr_ptr] <= 1'b1;
                wr_ptr            <= !wr_ptr;
            end
        end
    end

    // bank contents
    always_ff @(posedge clk) begin
        if (filtered.valid) begin
            bank_line[wr_ptr][filtered.s] <= filtered.val;
        end
        // angle stamped with the last bin
        if (line_end) begin
            bank_angle[wr_ptr] <= filtered.angle;
        end
    end

endmodule

//--- source/nabp_image_addresser.sv
`timescale 1ns/100ps

module nabp_image_addresser import nabp_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          sg_done,
    input  logic                          ir_enable,
    output logic                          ir_kick,
    output logic                          ir_done,
    output logic                          ir_addr_valid,
    output logic [k_image_addr_width-1:0] ir_addr
);

    logic consume;
    logic last_addr;

    // a pixel leaves on every enabled cycle
    assign consume   = ir_addr_valid && ir_enable;
    assign last_addr = (ir_addr == k_image_addr_width'(k_image_size * k_image_size - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            ir_kick       <= 1'b0;
            ir_done       <= 1'b0;
            ir_addr_valid <= 1'b0;
            ir_addr       <= '0;
        end else begin
            ir_kick <= sg_done;
            ir_done <= consume && last_addr;
            if (sg_done) begin
                ir_addr_valid <= 1'b1;
                ir_addr       <= '0;
            end else if (consume) begin
                ir_addr <= ir_addr + 1'b1;
                // valid drops together with the done pulse
                if (last_addr) ir_addr_valid <= 1'b0;
            end
        end
    end

endmodule

//--- source/nabp_pkg.sv
package nabp_pkg;

    // frame geometry
    localparam int k_angle_count = 4;
    localparam int k_s_count = 8;
    localparam int k_image_size = 8;
    localparam int k_partition_count = 4;
    localparam int k_rows_per_pe = 2;
    localparam int k_pixels_per_pe = 16;

    // datapath widths
    localparam int k_data_width = 8;
    localparam int k_filtered_width = 11;
    localparam int k_cache_width = 16;
    localparam int k_sinogram_addr_width = 5;
    localparam int k_image_addr_width = 6;
    localparam int k_angle_width = 2;
    localparam int k_s_width = 3;

    // projection direction, encoding equals the angle index
    typedef enum logic [k_angle_width-1:0] {
        proj_x    = 2'd0,
        proj_y    = 2'd1,
        proj_diag = 2'd2,
        proj_anti = 2'd3
    } projection_t;

    typedef enum logic [1:0] {
        sa_idle,
        sa_issue,
        sa_wait_stored,
        sa_wait_bank
    } sinogram_addresser_state_t;

    typedef enum logic [1:0] {
        ps_idle,
        ps_run,
        ps_release
    } processing_state_t;

    // tag of the sinogram sample arriving from RAM
    typedef struct packed {
        logic                 valid;
        projection_t          angle;
        logic [k_s_width-1:0] s;
    } sample_tag_t;

    typedef logic signed [k_filtered_width-1:0] filtered_value_t;

    // one filtered value headed for a line bank
    typedef struct packed {
        logic                 valid;
        projection_t          angle;
        logic [k_s_width-1:0] s;
        filtered_value_t      val;
    } filtered_sample_t;

    // a whole filtered line, index is the bin
    typedef filtered_value_t [k_s_count-1:0] line_t;

    // start of one backprojection pass
    typedef struct packed {
        logic        kick;
        projection_t angle;
    } pe_command_t;

    // detector bin hit by pixel (x, y) for a given direction
    function automatic logic [k_s_width-1:0] projection_s(
        input projection_t          angle,
        input logic [k_s_width-1:0] x,
        input logic [k_s_width-1:0] y
    );
        logic [k_s_width:0] sum;
        sum = '0;
        case (angle)
            proj_x: return x;
            proj_y: return y;
            proj_diag: begin
                sum = {1'b0, x} + {1'b0, y};
                return sum[k_s_width:1];
            end
            default: begin
                // x + 7 - y never goes negative
                sum = {1'b0, x} + (k_s_width + 1)'(k_s_count - 1) - {1'b0, y};
                return sum[k_s_width:1];
            end
        endcase
    endfunction

endpackage

//--- source/nabp_processing_element.sv
`timescale 1ns/100ps

module nabp_processing_element import nabp_pkg::*; #(
    parameter int pe_id = 0
) (
    input  logic                            clk,
    input  logic                            reset,
    input  pe_command_t                     pe_command,
    input  line_t                           taps,
    input  logic                            ir_enable,
    input  logic                            domino_kick,
    input  logic signed [k_cache_width-1:0] in_val,
    output logic                            domino_done,
    output logic signed [k_cache_width-1:0] out_val
);

    // two image rows, row major
    logic signed [k_cache_width-1:0] cache [k_pixels_per_pe];

    // backprojection pass
    logic                               pass_active;
    logic [$clog2(k_pixels_per_pe)-1:0] pass_idx;
    projection_t                        pass_angle;
    logic [k_s_width-1:0]               pass_x;
    logic [k_s_width-1:0]               pass_y;
    logic [k_s_width-1:0]               tap_s;
    filtered_value_t                    tap_val;
    logic signed [k_cache_width-1:0]    tap_ext;

    // readout token
    logic                               holding;
    logic [$clog2(k_pixels_per_pe)-1:0] out_idx;

    // pixel position from the pass index
    assign pass_x = k_s_width'(int'(pass_idx) % k_image_size);
    assign pass_y = k_s_width'(pe_id * k_rows_per_pe + int'(pass_idx) / k_image_size);

    assign tap_s   = projection_s(pass_angle, pass_x, pass_y);
    assign tap_val = taps[tap_s];
    // sign extension to the cache width
    assign tap_ext = tap_val;

    always_ff @(posedge clk) begin
        if (reset) begin
            pass_active <= 1'b0;
            pass_idx    <= '0;
            pass_angle  <= proj_x;
        end else if (pe_command.kick) begin
            pass_active <= 1'b1;
            pass_idx    <= '0;
            pass_angle  <= pe_command.angle;
        end else if (pass_active) begin
            pass_idx <= pass_idx + 1'b1;
            if (pass_idx == ($clog2(k_pixels_per_pe))'(k_pixels_per_pe - 1)) begin
                pass_active <= 1'b0;
            end
        end
    end

    // first angle overwrites, later angles accumulate
    always_ff @(posedge clk) begin
        if (pass_active) begin
            if (pass_angle == proj_x) cache[pass_idx] <= tap_ext;
            else cache[pass_idx] <= cache[pass_idx] + tap_ext;
        end
    end

    // token passes on with the last enabled pixel
    assign domino_done = holding && ir_enable &&
                         (out_idx == ($clog2(k_pixels_per_pe))'(k_pixels_per_pe - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            holding <= 1'b0;
            out_idx <= '0;
        end else if (domino_kick) begin
            holding <= 1'b1;
            out_idx <= '0;
        end else if (holding && ir_enable) begin
            out_idx <= out_idx + 1'b1;
            if (domino_done) holding <= 1'b0;
        end
    end

    // own pixel while holding, else upstream value
    assign out_val = holding ? cache[out_idx] : in_val;

endmodule

//--- source/nabp_processing_swap_control.sv
`timescale 1ns/100ps

module nabp_processing_swap_control import nabp_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        rd_full,
    input  projection_t rd_angle,
    output pe_command_t pe_command,
    output logic        bank_release,
    output logic        sg_done
);

    processing_state_t                    state;
    logic [$clog2(k_pixels_per_pe)-1:0]   pass_count;
    projection_t                          pass_angle;

    // kick as soon as a full bank waits
    assign pe_command.kick  = (state == ps_idle) && rd_full;
    assign pe_command.angle = rd_angle;

    // release lasts the single cycle after the pass
    assign bank_release = (state == ps_release);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ps_idle;
            pass_count <= '0;
            pass_angle <= proj_x;
            sg_done    <= 1'b0;
        end else begin
            // frame ends once the last angle's bank is handed back
            sg_done <= (state == ps_release) && (pass_angle == proj_anti);
            case (state)
                ps_idle: begin
                    if (rd_full) begin
                        state      <= ps_run;
                        pass_count <= '0;
                        pass_angle <= rd_angle;
                    end
                end
                ps_run: begin
                    // one pixel per element each cycle
                    pass_count <= pass_count + 1'b1;
                    if (pass_count == ($clog2(k_pixels_per_pe))'(k_pixels_per_pe - 1)) begin
                        state <= ps_release;
                    end
                end
                ps_release: begin
                    state <= ps_idle;
                end
                default: begin
                    state <= ps_idle;
                end
            endcase
        end
    end

endmodule

//--- source/nabp_sinogram_addresser.sv
`timescale 1ns/100ps

module nabp_sinogram_addresser import nabp_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             sg_kick,
    input  logic                             bank_stored,
    input  logic                             bank_free,
    output logic                             sg_read,
    output logic [k_sinogram_addr_width-1:0] sg_addr,
    output sample_tag_t                      sample_tag
);

    sinogram_addresser_state_t state;
    projection_t               angle;
    logic [k_s_width-1:0]      s;

    // reads only in the issue state, address is angle*8 + s
    assign sg_read = (state == sa_issue);
    assign sg_addr = {angle, s};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= sa_idle;
            angle <= proj_x;
            s     <= '0;
        end else begin
            case (state)
                sa_idle: begin
                    // kick only honoured here
                    if (sg_kick) begin
                        state <= sa_issue;
                        angle <= proj_x;
                        s     <= '0;
                    end
                end
                sa_issue: begin
                    // s wraps back to 0 after the last bin
                    s <= s + 1'b1;
                    if (s == k_s_width'(k_s_count - 1)) begin
                        if (angle == projection_t'(k_angle_count - 1)) begin
                            state <= sa_idle;
                        end else begin
                            state <= sa_wait_stored;
                            angle <= projection_t'(angle + 1'b1);
                        end
                    end
                end
                // line just issued must land in its bank first
                sa_wait_stored: if (bank_stored) state <= sa_wait_bank;
                // write pointer has moved, look at the new bank
                sa_wait_bank:   if (bank_free) state <= sa_issue;
                default:        state <= sa_idle;
            endcase
        end
    end

    // tag lines up with sg_val one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            sample_tag.valid <= 1'b0;
        end else begin
            sample_tag.valid <= sg_read;
        end
    end

    always_ff @(posedge clk) begin
        sample_tag.angle <= angle;
        sample_tag.s     <= s;
    end

endmodule

//--- tb.f
source/nabp_pkg.sv
source/nabp_sinogram_addresser.sv
source/nabp_filter.sv
source/nabp_filtered_ram_swap_control.sv
source/nabp_processing_swap_control.sv
source/nabp_processing_element.sv
source/nabp_image_addresser.sv
source/nabp.sv
verification/nabp_tb_clock.sv
verification/nabp_tb.sv

//--- verification/nabp_tb.sv
`timescale 1ns/100ps

module nabp_tb import nabp_pkg::*; ();

    localparam int k_frame_count     = 3;
    localparam int k_reset_timeout   = 10;
    localparam int k_frame_timeout   = 1000;
    localparam int k_readout_timeout = 1000;
    localparam int k_pixel_count     = k_image_size * k_image_size;
    localparam int k_sample_count    = k_angle_count * k_s_count;

    logic clk;
    logic reset;

    // dut inputs
    logic                    sg_kick;
    logic [k_data_width-1:0] sg_val;
    logic                    ir_enable;

    // dut outputs
    logic                             sg_done;
    logic                             sg_read;
    logic [k_sinogram_addr_width-1:0] sg_addr;
    logic                             ir_kick;
    logic                             ir_done;
    logic                             ir_addr_valid;
    logic [k_image_addr_width-1:0]    ir_addr;
    logic signed [k_cache_width-1:0]  ir_val;

    // sinogram ram contents and predicted image
    logic [k_data_width-1:0]         sinogram     [k_sample_count];
    logic signed [k_cache_width-1:0] expected_pix [k_pixel_count];
    logic [31:0]                     lfsr_state = 32'h2c0d;
    int                              errors = 0;
    int                              timeouts = 0;

    // expected protocol state
    logic                          kicked;
    int                            read_count;
    int                            done_count;
    logic                          exp_valid;
    logic [k_image_addr_width-1:0] exp_ir_addr;
    logic                          kick_due;
    logic                          done_due;

    nabp_tb_clock clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    nabp u_nabp (
        .clk           (clk),
        .reset         (reset),
        .sg_kick       (sg_kick),
        .sg_val        (sg_val),
        .ir_enable     (ir_enable),
        .sg_done       (sg_done),
        .sg_read       (sg_read),
        .sg_addr       (sg_addr),
        .ir_kick       (ir_kick),
        .ir_done       (ir_done),
        .ir_addr_valid (ir_addr_valid),
        .ir_addr       (ir_addr),
        .ir_val        (ir_val)
    );

    // 32 bit fibonacci lfsr, taps 32 22 2 1
    function automatic logic take_random_bit();
        logic feedback;
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return lfsr_state[0];
    endfunction

    task automatic report_mismatch(input string name, input int got, input int expected);
        $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, expected);
        errors++;
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        errors++;
    endtask

    // sinogram ram, one cycle read latency
    always @(posedge clk) begin
        if (sg_read) sg_val <= sinogram[sg_addr];
    end

    // what the dut should be doing, from the protocol rules
    always @(posedge clk) begin
        if (reset) begin
            kicked      <= 1'b0;
            read_count  <= 0;
            done_count  <= 0;
            exp_valid   <= 1'b0;
            exp_ir_addr <= '0;
            kick_due    <= 1'b0;
            done_due    <= 1'b0;
        end else begin
            if (sg_kick) begin
                kicked     <= 1'b1;
                read_count <= 0;
                done_count <= 0;
            end else begin
                if (sg_read) read_count <= read_count + 1;
                if (sg_done) done_count <= done_count + 1;
            end
            // readout starts the cycle after sg_done
            kick_due <= sg_done;
            done_due <= exp_valid && ir_enable && (exp_ir_addr == k_pixel_count - 1);
            if (sg_done) begin
                exp_valid   <= 1'b1;
                exp_ir_addr <= '0;
            end else if (exp_valid && ir_enable) begin
                exp_ir_addr <= exp_ir_addr + 1'b1;
                if (exp_ir_addr == k_pixel_count - 1) exp_valid <= 1'b0;
            end
        end
    end

    // quiet outputs until the first kick
    idle_before_kick: assert property (@(posedge clk) disable iff (reset)
        !kicked |-> !(sg_read || sg_done || ir_kick || ir_done || ir_addr_valid))
        else report_error("output strobe active before the first sg_kick");

    read_in_range: assert property (@(posedge clk) disable iff (reset)
        sg_read |-> read_count < k_sample_count)
        else report_error("more than 32 sinogram reads in one frame");

    read_order: assert property (@(posedge clk) disable iff (reset)
        sg_read |-> int'(sg_addr) == read_count)
        else report_mismatch("sg_addr", int'($sampled(sg_addr)), $sampled(read_count));

    done_after_reads: assert property (@(posedge clk) disable iff (reset)
        sg_done |-> read_count == k_sample_count)
        else report_error("sg_done before all 32 sinogram reads");

    done_once: assert property (@(posedge clk) disable iff (reset)
        sg_done |-> done_count == 0)
        else report_error("sg_done pulsed twice in one frame");

    kick_timing: assert property (@(posedge clk) disable iff (reset)
        ir_kick == kick_due)
        else report_mismatch("ir_kick", $sampled(ir_kick), $sampled(kick_due));

    valid_level: assert property (@(posedge clk) disable iff (reset)
        ir_addr_valid == exp_valid)
        else report_mismatch("ir_addr_valid", $sampled(ir_addr_valid), $sampled(exp_valid));

    addr_order: assert property (@(posedge clk) disable iff (reset)
        ir_addr_valid |-> ir_addr == exp_ir_addr)
        else report_mismatch("ir_addr", int'($sampled(ir_addr)), int'($sampled(exp_ir_addr)));

    done_timing: assert property (@(posedge clk) disable iff (reset)
        ir_done == done_due)
        else report_mismatch("ir_done", $sampled(ir_done), $sampled(done_due));

    // every consumed pixel against the reference image
    pixel_value: assert property (@(posedge clk) disable iff (reset)
        (exp_valid && ir_enable) |-> ir_val == expected_pix[exp_ir_addr])
        else report_mismatch("ir_val", int'($sampled(ir_val)),
                             int'(expected_pix[$sampled(exp_ir_addr)]));

    // fresh bytes, msb first, 8 lfsr steps each
    task automatic fill_sinogram();
        logic [k_data_width-1:0] sample;
        for (int addr = 0; addr < k_sample_count; addr++) begin
            sample = '0;
            for (int b = 0; b < k_data_width; b++) begin
                sample = {sample[k_data_width-2:0], take_random_bit()};
            end
            sinogram[addr] = sample;
        end
    endtask

    // two-tap filter then the four bin rules, summed per pixel
    task automatic build_reference();
        int filt [k_angle_count][k_s_count];
        int prev;
        int sum;
        for (int a = 0; a < k_angle_count; a++) begin
            for (int s = 0; s < k_s_count; s++) begin
                prev = (s == 0) ? 0 : int'(sinogram[a * k_s_count + s - 1]);
                filt[a][s] = 2 * int'(sinogram[a * k_s_count + s]) - prev;
            end
        end
        for (int y = 0; y < k_image_size; y++) begin
            for (int x = 0; x < k_image_size; x++) begin
                sum = filt[0][x] + filt[1][y] + filt[2][(x + y) / 2] + filt[3][(x + 7 - y) / 2];
                expected_pix[y * k_image_size + x] = sum;
            end
        end
    endtask

    // one kick, backprojection, then full image readout
    task automatic run_frame(input int frame, input bit random_enable);
        int cycles;
        @(posedge clk);
        sg_kick <= 1'b1;
        @(posedge clk);
        sg_kick <= 1'b0;
        cycles = 0;
        while (!sg_done && cycles < k_frame_timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (!sg_done) begin
            $display("ERROR at %0t: timed out waiting for sg_done in frame %0d", $time, frame);
            timeouts++;
            return;
        end
        // enable for the first readout cycle goes out on this edge
        cycles = 0;
        if (random_enable) ir_enable <= take_random_bit();
        else ir_enable <= 1'b1;
        while (!ir_done && cycles < k_readout_timeout) begin
            @(posedge clk);
            cycles++;
            if (random_enable) ir_enable <= take_random_bit();
            else ir_enable <= 1'b1;
        end
        ir_enable <= 1'b0;
        if (!ir_done) begin
            $display("ERROR at %0t: timed out waiting for ir_done in frame %0d", $time, frame);
            timeouts++;
        end
    endtask

    initial begin : main
        int cycles;
        sg_kick   = 1'b0;
        sg_val    = '0;
        ir_enable = 1'b0;
        cycles    = 0;
        @(posedge clk);
        while (reset && cycles < k_reset_timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (reset) begin
            $display("ERROR at %0t: reset never released", $time);
            timeouts++;
        end else begin
            // idle stretch before the first kick
            repeat (5) @(posedge clk);
            // frame 0 reads continuously, later frames under lfsr back-pressure
            for (int frame = 0; frame < k_frame_count && timeouts == 0; frame++) begin
                fill_sinogram();
                build_reference();
                run_frame(frame, frame != 0);
            end
        end
        repeat (2) @(posedge clk);
        $display("check failures: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verification/nabp_tb_clock.sv
`timescale 1ns/100ps

module nabp_tb_clock (
    output logic clk,
    output logic reset
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held for the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule
